// File: src/alu_pkg.sv
/*
 * alu package: operand and flag widths, opcodes, queue sizing and the
 * operand word that reads as a pair or as hi/lo bytes
 */
`default_nettype none

package alu_pkg;

	// one ALU byte and one register pair
	localparam int BYTE_WIDTH = 8;
	localparam int PAIR_WIDTH = 16;

	// flags word, only C and Z survive
	localparam int FLAG_WIDTH = 2;
	localparam int FLAG_C = 0;
	localparam int FLAG_Z = 1;

	localparam int OP_WIDTH = 5;

	// result queue entries, also the sender's credits after reset
	localparam int QUEUE_DEPTH = 4;
	localparam int QUEUE_ADDR_WIDTH = 2;

	// output credit counter width
	localparam int CREDIT_WIDTH = 16;

	// codes 30 and 31 are undefined and pass A through
	typedef enum logic [OP_WIDTH-1:0] {
		alu_op_add, alu_op_adc, alu_op_addpb, alu_op_addp, alu_op_addpsnx,
		alu_op_sub, alu_op_sbc, alu_op_subpb, alu_op_subp,
		alu_op_and, alu_op_orr, alu_op_xor,
		alu_op_inv, alu_op_invp, alu_op_neg, alu_op_negp,
		alu_op_lsl, alu_op_lsr, alu_op_asr, alu_op_rol, alu_op_ror,
		alu_op_rolc, alu_op_rorc,
		alu_op_lslp, alu_op_lsrp, alu_op_asrp, alu_op_rolp, alu_op_rorp,
		alu_op_rolcp, alu_op_rorcp
	} alu_op_t;

	// same 16 bits, pair ops use pair, byte ops use bytes.lo
	typedef union packed {
		logic [PAIR_WIDTH-1:0] pair;
		struct packed {
			logic [BYTE_WIDTH-1:0] hi;
			logic [BYTE_WIDTH-1:0] lo;
		} bytes;
	} operand_t;

	// Z judged on the whole pair for these, on the lo byte otherwise
	function automatic logic is_pair_op(alu_op_t op);
		return op inside {
			alu_op_addpb, alu_op_addp, alu_op_addpsnx,
			alu_op_subpb, alu_op_subp,
			alu_op_invp, alu_op_negp,
			alu_op_lslp, alu_op_lsrp, alu_op_asrp,
			alu_op_rolp, alu_op_rorp, alu_op_rolcp, alu_op_rorcp
		};
	endfunction

endpackage

`default_nettype wire

// File: src/addsub_unit.sv
/*
 * adder/subtractor: byte and pair add and subtract forms on one
 * 17-bit adder, carry out means no borrow for subtracts
 */
`timescale 1ns/1ns
`default_nettype none

module addsub_unit (
	input  alu_pkg::alu_op_t op,
	input  alu_pkg::operand_t a,
	input  alu_pkg::operand_t b,
	input  logic carry_in,
	output alu_pkg::operand_t sum,
	output logic carry_out
);
	import alu_pkg::*;

	logic is_addsub;
	logic pair_mode;
	logic subtract;
	logic cin;
	logic [PAIR_WIDTH-1:0] b_ext;
	logic [PAIR_WIDTH-1:0] b_inv;
	logic [PAIR_WIDTH-1:0] x_opnd;
	logic [PAIR_WIDTH-1:0] y_opnd;
	logic [PAIR_WIDTH:0] full_sum;

	assign is_addsub = op inside {alu_op_add, alu_op_adc, alu_op_addpb, alu_op_addp,
		alu_op_addpsnx, alu_op_sub, alu_op_sbc, alu_op_subpb, alu_op_subp};
	assign pair_mode = op inside {alu_op_addpb, alu_op_addp, alu_op_addpsnx,
		alu_op_subpb, alu_op_subp};
	assign subtract = op inside {alu_op_sub, alu_op_sbc, alu_op_subpb, alu_op_subp};

	// adc/sbc chain C, plain subtracts need the +1 of two's complement
	always_comb
	begin
		case (op)
			alu_op_adc, alu_op_sbc: cin = carry_in;
			alu_op_sub, alu_op_subpb, alu_op_subp: cin = 1'b1;
			default: cin = 1'b0;
		endcase
	end

	// b operand: full pair, zero-extended byte or sign-extended byte
	always_comb
	begin
		case (op)
			alu_op_addp, alu_op_subp: b_ext = b.pair;
			alu_op_addpsnx: b_ext = {{BYTE_WIDTH{b.bytes.lo[BYTE_WIDTH-1]}}, b.bytes.lo};
			default: b_ext = {{BYTE_WIDTH{1'b0}}, b.bytes.lo};
		endcase
	end

	assign b_inv = subtract ? ~b_ext : b_ext;

	// byte forms sit in the low half, carry lands on bit 8
	assign x_opnd = pair_mode ? a.pair : {{BYTE_WIDTH{1'b0}}, a.bytes.lo};
	assign y_opnd = pair_mode ? b_inv : {{BYTE_WIDTH{1'b0}}, b_inv[BYTE_WIDTH-1:0]};
	assign full_sum = {1'b0, x_opnd} + {1'b0, y_opnd} + {{PAIR_WIDTH{1'b0}}, cin};

	always_comb
	begin
		sum = a;
		carry_out = carry_in;
		if (is_addsub)
		begin
			if (pair_mode)
			begin
				sum.pair = full_sum[PAIR_WIDTH-1:0];
				carry_out = full_sum[PAIR_WIDTH];
			end
			else
			begin
				// hi byte stays a_hi
				sum.bytes.lo = full_sum[BYTE_WIDTH-1:0];
				carry_out = full_sum[BYTE_WIDTH];
			end
		end
	end

endmodule

`default_nettype wire

// File: src/shift_rotate_unit.sv
/*
 * shift/rotate unit: byte and pair logical and arithmetic shifts,
 * masked-amount rotates and one-bit rotates through carry
 */
`timescale 1ns/1ns
`default_nettype none

module shift_rotate_unit (
	input  alu_pkg::alu_op_t op,
	input  alu_pkg::operand_t a,
	input  logic [alu_pkg::BYTE_WIDTH-1:0] amount,
	input  logic carry_in,
	output alu_pkg::operand_t shifted,
	output logic carry_out,
	output logic unchanged
);
	import alu_pkg::*;

	// shifts carry one extra bit for C, {c,x} left and {x,c} right
	logic [BYTE_WIDTH:0] lsl_b;
	logic [BYTE_WIDTH:0] lsr_b;
	logic [BYTE_WIDTH:0] asr_b;
	logic [PAIR_WIDTH:0] lsl_p;
	logic [PAIR_WIDTH:0] lsr_p;
	logic [PAIR_WIDTH:0] asr_p;
	// rotates on a doubled copy of the operand
	logic [2*BYTE_WIDTH-1:0] rot_l_b;
	logic [2*BYTE_WIDTH-1:0] rot_r_b;
	logic [2*PAIR_WIDTH-1:0] rot_l_p;
	logic [2*PAIR_WIDTH-1:0] rot_r_p;
	logic [BYTE_WIDTH-1:0] rot_amt_b;
	logic [BYTE_WIDTH-1:0] rot_amt_p;
	logic past_byte;
	logic past_pair;
	logic amount_op;

	assign lsl_b = {1'b0, a.bytes.lo} << amount;
	assign lsr_b = {a.bytes.lo, 1'b0} >> amount;
	assign asr_b = $signed({a.bytes.lo, 1'b0}) >>> amount;
	assign lsl_p = {1'b0, a.pair} << amount;
	assign lsr_p = {a.pair, 1'b0} >> amount;
	assign asr_p = $signed({a.pair, 1'b0}) >>> amount;

	// amount beyond the width leaves nothing to shift out
	assign past_byte = amount > BYTE_WIDTH;
	assign past_pair = amount > PAIR_WIDTH;

	// rotate amount modulo width, widths are powers of two
	assign rot_amt_b = amount & BYTE_WIDTH'(BYTE_WIDTH - 1);
	assign rot_amt_p = amount & BYTE_WIDTH'(PAIR_WIDTH - 1);
	assign rot_l_b = {a.bytes.lo, a.bytes.lo} << rot_amt_b;
	assign rot_r_b = {a.bytes.lo, a.bytes.lo} >> rot_amt_b;
	assign rot_l_p = {a.pair, a.pair} << rot_amt_p;
	assign rot_r_p = {a.pair, a.pair} >> rot_amt_p;

	// zero amount on these keeps result and both flags
	assign amount_op = op inside {alu_op_lsl, alu_op_lsr, alu_op_asr, alu_op_rol,
		alu_op_ror, alu_op_lslp, alu_op_lsrp, alu_op_asrp, alu_op_rolp, alu_op_rorp};
	assign unchanged = amount_op && (amount == '0);

	always_comb
	begin
		shifted = a;
		carry_out = carry_in;
		if (!unchanged)
		begin
			case (op)
				alu_op_lsl:
				begin
					shifted.bytes.lo = lsl_b[BYTE_WIDTH-1:0];
					carry_out = lsl_b[BYTE_WIDTH];
				end
				alu_op_lsr:
				begin
					shifted.bytes.lo = lsr_b[BYTE_WIDTH:1];
					carry_out = lsr_b[0];
				end
				alu_op_asr:
				begin
					shifted.bytes.lo = asr_b[BYTE_WIDTH:1];
					carry_out = past_byte ? 1'b0 : asr_b[0];
				end
				// rotates keep C
				alu_op_rol: shifted.bytes.lo = rot_l_b[2*BYTE_WIDTH-1:BYTE_WIDTH];
				alu_op_ror: shifted.bytes.lo = rot_r_b[BYTE_WIDTH-1:0];
				// 9-bit rotate of {c, lo} by one
				alu_op_rolc: {carry_out, shifted.bytes.lo} = {a.bytes.lo, carry_in};
				alu_op_rorc: {shifted.bytes.lo, carry_out} = {carry_in, a.bytes.lo};
				alu_op_lslp:
				begin
					shifted.pair = lsl_p[PAIR_WIDTH-1:0];
					carry_out = lsl_p[PAIR_WIDTH];
				end
				alu_op_lsrp:
				begin
					shifted.pair = lsr_p[PAIR_WIDTH:1];
					carry_out = lsr_p[0];
				end
				alu_op_asrp:
				begin
					shifted.pair = asr_p[PAIR_WIDTH:1];
					carry_out = past_pair ? 1'b0 : asr_p[0];
				end
				alu_op_rolp: shifted.pair = rot_l_p[2*PAIR_WIDTH-1:PAIR_WIDTH];
				alu_op_rorp: shifted.pair = rot_r_p[PAIR_WIDTH-1:0];
				// 17-bit rotate of {c, pair}
				alu_op_rolcp: {carry_out, shifted.pair} = {a.pair, carry_in};
				alu_op_rorcp: {shifted.pair, carry_out} = {carry_in, a.pair};
				default: shifted = a;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: src/alu_exec.sv
/*
 * ALU execute stage: bitwise and complement ops, selection between the
 * function units by opcode group, C/Z flag update
 */
`timescale 1ns/1ns
`default_nettype none

module alu_exec (
	input  alu_pkg::alu_op_t op,
	input  alu_pkg::operand_t a,
	input  alu_pkg::operand_t b,
	input  logic [alu_pkg::FLAG_WIDTH-1:0] flags_in,
	output alu_pkg::operand_t result,
	output logic [alu_pkg::FLAG_WIDTH-1:0] flags_out
);
	import alu_pkg::*;

	operand_t add_sum;
	operand_t shift_res;
	logic add_c;
	logic shift_c;
	logic shift_keep;
	logic c_out;
	logic keep_z;
	logic z_calc;

	addsub_unit u_addsub (
		.op(op),
		.a(a),
		.b(b),
		.carry_in(flags_in[FLAG_C]),
		.sum(add_sum),
		.carry_out(add_c)
	);

	// shift amount always comes from b lo
	shift_rotate_unit u_shift (
		.op(op),
		.a(a),
		.amount(b.bytes.lo),
		.carry_in(flags_in[FLAG_C]),
		.shifted(shift_res),
		.carry_out(shift_c),
		.unchanged(shift_keep)
	);

	always_comb
	begin
		result = a;
		c_out = flags_in[FLAG_C];
		keep_z = 1'b0;
		case (op)
			alu_op_add, alu_op_adc, alu_op_addpb, alu_op_addp, alu_op_addpsnx,
			alu_op_sub, alu_op_sbc, alu_op_subpb, alu_op_subp:
			begin
				result = add_sum;
				c_out = add_c;
			end
			// logic ops keep C and a_hi
			alu_op_and: result.bytes.lo = a.bytes.lo & b.bytes.lo;
			alu_op_orr: result.bytes.lo = a.bytes.lo | b.bytes.lo;
			alu_op_xor: result.bytes.lo = a.bytes.lo ^ b.bytes.lo;
			// complements, C kept too
			alu_op_inv: result.bytes.lo = ~a.bytes.lo;
			alu_op_invp: result.pair = ~a.pair;
			alu_op_neg: result.bytes.lo = -a.bytes.lo;
			alu_op_negp: result.pair = -a.pair;
			alu_op_lsl, alu_op_lsr, alu_op_asr, alu_op_rol, alu_op_ror,
			alu_op_rolc, alu_op_rorc, alu_op_lslp, alu_op_lsrp, alu_op_asrp,
			alu_op_rolp, alu_op_rorp, alu_op_rolcp, alu_op_rorcp:
			begin
				result = shift_res;
				c_out = shift_c;
				keep_z = shift_keep;
			end
			// undefined codes, A through and both flags held
			default: keep_z = 1'b1;
		endcase
	end

	// Z on lo for byte ops, whole pair for pair ops
	assign z_calc = is_pair_op(op) ? (result.pair == '0) : (result.bytes.lo == '0);
	assign flags_out[FLAG_Z] = keep_z ? flags_in[FLAG_Z] : z_calc;
	assign flags_out[FLAG_C] = c_out;

endmodule

`default_nettype wire

// File: src/result_queue.sv
/*
 * result queue: in-order FIFO of results and flags, pops against
 * consumer-granted output credits, each pop returns one input credit
 */
`timescale 1ns/1ns
`default_nettype none

module result_queue (
	input  logic clk,
	input  logic rst_n,
	input  logic push,
	input  alu_pkg::operand_t push_result,
	input  logic [alu_pkg::FLAG_WIDTH-1:0] push_flags,
	input  logic out_credit,
	output logic out_valid,
	output alu_pkg::operand_t out_result,
	output logic [alu_pkg::FLAG_WIDTH-1:0] out_flags,
	output logic in_credit
);
	import alu_pkg::*;

	operand_t result_mem [QUEUE_DEPTH];
	logic [FLAG_WIDTH-1:0] flags_mem [QUEUE_DEPTH];
	logic [QUEUE_ADDR_WIDTH-1:0] wr_ptr;
	logic [QUEUE_ADDR_WIDTH-1:0] rd_ptr;
	logic [QUEUE_ADDR_WIDTH:0] count;
	logic [CREDIT_WIDTH-1:0] credits;
	logic pop;

	// one pop per cycle while an entry and a credit are both there
	assign pop = (count != '0) && (credits != '0);
	assign out_valid = pop;
	// input credit paid in the same cycle as the transfer
	assign in_credit = pop;
	assign out_result = result_mem[rd_ptr];
	assign out_flags = flags_mem[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (push)
		begin
			result_mem[wr_ptr] <= push_result;
			flags_mem[wr_ptr] <= push_flags;
		end
	end

	// pointers wrap on their own, depth is a power of two
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// grants in, transfers out
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			credits <= '0;
		else
		begin
			case ({out_credit, pop})
				2'b10: credits <= credits + 1'b1;
				2'b01: credits <= credits - 1'b1;
				default: credits <= credits;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: src/alu_unit.sv
/*
 * streaming ALU top: issue register, combinational execute stage,
 * credit-controlled result queue
 */
`timescale 1ns/1ns
`default_nettype none

module alu_unit (
	input  logic clk,
	input  logic rst_n,
	input  logic in_valid,
	input  alu_pkg::alu_op_t in_op,
	input  alu_pkg::operand_t in_a,
	input  alu_pkg::operand_t in_b,
	input  logic [alu_pkg::FLAG_WIDTH-1:0] in_flags,
	input  logic out_credit,
	output logic out_valid,
	output alu_pkg::operand_t out_result,
	output logic [alu_pkg::FLAG_WIDTH-1:0] out_flags,
	output logic in_credit
);
	import alu_pkg::*;

	logic iss_valid;
	alu_op_t iss_op;
	operand_t iss_a;
	operand_t iss_b;
	logic [FLAG_WIDTH-1:0] iss_flags;
	operand_t exec_result;
	logic [FLAG_WIDTH-1:0] exec_flags;

	// issue valid, never stalls since credits bound the queue
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			iss_valid <= 1'b0;
		else
			iss_valid <= in_valid;
	end

	// operation payload
	always_ff @(posedge clk)
	begin
		if (in_valid)
		begin
			iss_op <= in_op;
			iss_a <= in_a;
			iss_b <= in_b;
			iss_flags <= in_flags;
		end
	end

	alu_exec u_exec (
		.op(iss_op),
		.a(iss_a),
		.b(iss_b),
		.flags_in(iss_flags),
		.result(exec_result),
		.flags_out(exec_flags)
	);

	// result written one edge after issue
	result_queue u_queue (
		.clk(clk),
		.rst_n(rst_n),
		.push(iss_valid),
		.push_result(exec_result),
		.push_flags(exec_flags),
		.out_credit(out_credit),
		.out_valid(out_valid),
		.out_result(out_result),
		.out_flags(out_flags),
		.in_credit(in_credit)
	);

endmodule

`default_nettype wire

// File: tests/alu_unit_chk.sv
/*
 * credit and queue checker for the streaming ALU, bound into alu_unit
 */
`timescale 1ns/1ns
`default_nettype none

module alu_unit_chk (
	input  logic clk,
	input  logic rst_n,
	input  logic push,
	input  logic out_credit,
	input  logic out_valid,
	input  logic [alu_pkg::QUEUE_ADDR_WIDTH:0] queue_count
);
	import alu_pkg::*;

	// consumer grants seen at the port, minus transfers
	logic [CREDIT_WIDTH-1:0] granted;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			granted <= '0;
		else
			granted <= granted + out_credit - out_valid;
	end

	// never more entries than slots
	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		queue_count <= QUEUE_DEPTH)
		else $error("result queue holds more entries than its depth");

	// a push into a full queue only when the same edge pops
	a_full_push: assert property (@(posedge clk) disable iff (!rst_n)
		(push && queue_count == QUEUE_DEPTH) |-> out_valid)
		else $error("push into a full result queue without a pop");

	// every transfer spends a granted credit
	a_valid_credit: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> (granted != '0))
		else $error("out_valid raised with no output credit granted");

endmodule

bind alu_unit alu_unit_chk chk (
	.clk(clk),
	.rst_n(rst_n),
	.push(iss_valid),
	.out_credit(out_credit),
	.out_valid(out_valid),
	.queue_count(u_queue.count)
);

`default_nettype wire

// File: tests/tb_alu_unit.sv
/*
 * testbench for the streaming ALU: credit-limited stimulus from the
 * data file, in-order result and flag checks, timeout
 */
`timescale 1ns/1ns
`default_nettype none

module tb_alu_unit;
	import alu_pkg::*;

	// consumer holds back all credits in this cycle window
	localparam int HOLD_START = 20;
	localparam int HOLD_END = 60;

	logic clk;
	logic rst_n;
	logic in_valid;
	alu_op_t in_op;
	operand_t in_a;
	operand_t in_b;
	logic [FLAG_WIDTH-1:0] in_flags;
	logic out_credit;
	logic out_valid;
	operand_t out_result;
	logic [FLAG_WIDTH-1:0] out_flags;
	logic in_credit;

	// one entry per data file line
	string vec_name[$];
	logic [OP_WIDTH-1:0] vec_op[$];
	logic [FLAG_WIDTH-1:0] vec_flags[$];
	logic [PAIR_WIDTH-1:0] vec_a[$];
	logic [PAIR_WIDTH-1:0] vec_b[$];
	logic [PAIR_WIDTH-1:0] vec_result[$];
	logic [FLAG_WIDTH-1:0] vec_rflags[$];

	// issued but not yet delivered, in issue order
	int pending[$];
	int next_issue = 0;
	int sender_credits = QUEUE_DEPTH;
	int grants = 0;
	int results_seen = 0;
	int cycle = 0;
	int limit = 0;
	logic issued_any = 1'b0;
	logic saw_stall = 1'b0;
	logic [31:0] lfsr;

	alu_unit dut (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.in_op(in_op),
		.in_a(in_a),
		.in_b(in_b),
		.in_flags(in_flags),
		.out_credit(out_credit),
		.out_valid(out_valid),
		.out_result(out_result),
		.out_flags(out_flags),
		.in_credit(in_credit)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic fail_run(string msg);
		$display("%s", msg);
		$display("TEST FAIL");
		$fatal(1, "run stopped at the first error");
	endtask

	// Galois LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(logic [31:0] state);
		return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
	endfunction

	task automatic take_bit(output logic bit_out);
		bit_out = lfsr[0];
		lfsr = lfsr_step(lfsr);
	endtask

	task automatic load_vectors();
		int fd;
		int n;
		string line;
		string nm;
		logic [7:0] op;
		logic [3:0] fl;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] res;
		logic [3:0] rfl;
		fd = $fopen("tests/alu_testdata.txt", "r");
		assert (fd != 0)
		else fail_run("cannot open tests/alu_testdata.txt");
		while (!$feof(fd))
		begin
			line = "";
			n = $fgets(line, fd);
			// comment lines start with #
			if (n > 0 && line.getc(0) != "#")
			begin
				n = $sscanf(line, "%s %h %h %h %h %h %h", nm, op, fl, a, b, res, rfl);
				if (n == 7)
				begin
					vec_name.push_back(nm);
					vec_op.push_back(op[OP_WIDTH-1:0]);
					vec_flags.push_back(fl[FLAG_WIDTH-1:0]);
					vec_a.push_back(a);
					vec_b.push_back(b);
					vec_result.push_back(res);
					vec_rflags.push_back(rfl[FLAG_WIDTH-1:0]);
				end
			end
		end
		$fclose(fd);
		assert (vec_name.size() > 0)
		else fail_run("no test vectors found in the data file");
	endtask

	// sampled mid-cycle, outputs settled
	task automatic check_outputs();
		int idx;
		if (!issued_any)
		begin
			assert (out_valid === 1'b0 && in_credit === 1'b0)
			else fail_run("out_valid or in_credit high before any operation was issued");
		end
		assert (in_credit === out_valid)
		else fail_run("in_credit does not pulse together with out_valid");
		if (out_valid === 1'b1)
		begin
			assert (grants > results_seen)
			else fail_run("out_valid beyond the output credits granted");
			assert (pending.size() > 0)
			else fail_run("result delivered with no operation outstanding");
			idx = pending.pop_front();
			assert (out_result.pair === vec_result[idx] && out_flags === vec_rflags[idx])
			else fail_run($sformatf("mismatch %s: expected %h flags %b, actual %h flags %b",
				vec_name[idx], vec_result[idx], vec_rflags[idx], out_result.pair, out_flags));
			results_seen++;
		end
		if (in_credit === 1'b1)
			sender_credits++;
		// a grant driven this cycle counts from the next edge on
		if (out_credit)
			grants++;
	endtask

	initial
	begin
		logic coin;
		lfsr = 32'h6006_7bbe;
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_op = alu_op_add;
		in_a = '0;
		in_b = '0;
		in_flags = '0;
		out_credit = 1'b0;
		load_vectors();
		limit = 20 * vec_name.size() + 100;
		repeat (2) @(posedge clk);
		#5;
		rst_n = 1'b1;
		while (results_seen < vec_name.size())
		begin
			@(posedge clk);
			#5;
			cycle++;
			assert (cycle <= limit)
			else fail_run($sformatf("timeout after %0d cycles, %0d of %0d results seen",
				cycle, results_seen, vec_name.size()));
			// sender issues only while it holds a credit
			take_bit(coin);
			if (coin && sender_credits > 0 && next_issue < vec_name.size())
			begin
				in_valid = 1'b1;
				in_op = alu_op_t'(vec_op[next_issue]);
				in_a.pair = vec_a[next_issue];
				in_b.pair = vec_b[next_issue];
				in_flags = vec_flags[next_issue];
				pending.push_back(next_issue);
				next_issue++;
				sender_credits--;
				issued_any = 1'b1;
			end
			else
				in_valid = 1'b0;
			// starved while the consumer holds its credits back
			if (sender_credits == 0 && cycle >= HOLD_START && cycle < HOLD_END)
				saw_stall = 1'b1;
			// consumer grants at most a queue's worth ahead
			take_bit(coin);
			out_credit = coin && (cycle < HOLD_START || cycle >= HOLD_END)
				&& (grants - results_seen < QUEUE_DEPTH);
			@(negedge clk);
			check_outputs();
		end
		@(posedge clk);
		#5;
		in_valid = 1'b0;
		out_credit = 1'b0;
		// queue must be drained, no duplicates or stray credits trailing
		repeat (4)
		begin
			@(negedge clk);
			assert (out_valid === 1'b0 && in_credit === 1'b0)
			else fail_run("extra result or input credit after every operation was delivered");
		end
		assert (saw_stall)
		else fail_run("sender never ran out of credits while output credits were held");
		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: tests/alu_testdata.txt
# name opcode flags a b result result_flags, all hex after the name
# flags bit 1 is Z and bit 0 is C, opcodes in alu_op_t order
add_basic 00 0 1234 0011 1245 0
add_carry 00 0 ab80 0080 ab00 3
adc_cin 01 1 00ff 0000 0000 3
addpb 02 0 12f0 ff20 1310 0
addpb_carry 02 0 fff0 0010 0000 3
addp_carry 03 0 8000 8001 0001 1
addpsnx_neg 04 0 1000 00ff 0fff 1
addpsnx_pos 04 0 1000 ff7f 107f 0
sub_borrow 05 0 7710 0020 77f0 0
sub_zero 05 0 0042 0042 0000 3
sbc_nocin 06 0 0050 0030 001f 1
sbc_borrow 06 0 0000 0000 00ff 0
subpb 07 0 0100 0001 00ff 1
subp_borrow 08 0 0001 0002 ffff 0
subp_zero 08 0 abcd abcd 0000 3
and_zero 09 1 12f0 000f 1200 3
orr 0a 0 3400 0081 3481 0
xor_zero 0b 1 00aa 00aa 0000 3
inv 0c 0 56ff 0000 5600 2
invp 0d 1 00ff 0000 ff00 1
neg 0e 0 9901 0000 99ff 0
negp_zero 0f 2 0000 0000 0000 2
lsl 10 0 0081 0001 0002 1
lsl_amt0 10 3 1280 ff00 1280 3
lsl_by8 10 0 0001 0008 0000 3
lsl_past 10 1 00ff 0009 0000 2
lsr_by8 11 0 0080 0008 0000 3
asr 12 0 0081 0001 00c0 1
asr_past 12 1 0080 0010 00ff 0
rol 13 1 0081 0001 0003 1
rol_by8 13 2 0055 0008 0055 0
ror_masked 14 0 0001 0009 0080 0
rolc 15 1 0080 0000 0001 1
rorc 16 0 0001 0000 0000 3
lslp 17 0 8001 0001 0002 1
lsrp_amt0 18 2 0000 1200 0000 2
lsrp 18 0 0100 0009 0000 3
asrp 19 0 8000 0004 f800 0
asrp_past 19 1 8000 0011 ffff 0
rolp 1a 0 8001 0011 0003 0
rorp 1b 1 0001 0004 1000 1
rolcp 1c 0 8000 0000 0000 3
rorcp 1d 1 0000 0000 8000 0
undef_1e 1e 3 beef 1234 beef 3
undef_1f 1f 0 0000 ffff 0000 0

// File: tb.f
src/alu_pkg.sv
src/addsub_unit.sv
src/shift_rotate_unit.sv
src/alu_exec.sv
src/result_queue.sv
src/alu_unit.sv
tests/alu_unit_chk.sv
tests/tb_alu_unit.sv
